//--- hw/tcb_lite_params.svh
// bus widths, memory depth and response delay, included by the package and RTL modules
`ifndef TCB_LITE_PARAMS_SVH
`define TCB_LITE_PARAMS_SVH

// address width in bits
`define TCB_ADR 12
// data width in bits
`define TCB_DAT 32
// bytes per data word
`define TCB_BYT 4
// logarithmic size field width
`define TCB_SIZ 2

// memory depth in words, 1 KiB total
`define TCB_MEM_WORDS 256

// response delay in cycles after the handshake, 1 to 4
`define TCB_DLY 1

`endif

//--- hw/tcb_lite_pkg.sv
// TCB-Lite vector types and the shared byte ordering function, imported by the RTL modules
`include "tcb_lite_params.svh"

package tcb_lite_pkg;

    // byte address
    typedef logic [`TCB_ADR-1:0]                 adr_t;
    // data word
    typedef logic [`TCB_DAT-1:0]                 dat_t;
    // byte enables
    typedef logic [`TCB_BYT-1:0]                 byt_t;
    // log2 of access size in bytes, 3 is illegal
    typedef logic [`TCB_SIZ-1:0]                 siz_t;
    // memory word index
    typedef logic [$clog2(`TCB_MEM_WORDS)-1:0]   idx_t;
    // byte offset inside a word
    typedef logic [$clog2(`TCB_BYT)-1:0]         off_t;

    // item in lane 0 upward, reversed for big endian, bytes above size cleared
    function automatic dat_t item_order(dat_t dat, siz_t siz, logic ndn);
        int unsigned len;
        dat_t        res;
        len = 1 << siz;
        // size 3 only with err set, clamp to a full word
        if (len > `TCB_BYT) len = `TCB_BYT;
        res = '0;
        for (int unsigned i = 0; i < `TCB_BYT; i++) begin
            if (i < len) begin
                res[8*i+:8] = ndn ? dat[8*(len-1-i)+:8] : dat[8*i+:8];
            end
        end
        return res;
    endfunction

endpackage

//--- hw/tcb_lite_decode.sv
// request decode stage, turns a bus request into byte enables, lane data, word index and err
`timescale 1ns/1ps
`include "tcb_lite_params.svh"

module tcb_lite_decode import tcb_lite_pkg::*; (
    // request from the manager
    input  logic vld,
    input  logic rdy,
    input  logic wen,
    input  logic ndn,
    input  adr_t adr,
    input  siz_t siz,
    input  dat_t wdt,
    // decoded request towards execute
    output logic trn,
    output logic wr,
    output idx_t idx,
    output off_t off,
    output byt_t byt,
    output dat_t wdat,
    output logic err
);

    // byte address bits covered by the memory
    localparam int unsigned MEM_ADR = $clog2(`TCB_MEM_WORDS * `TCB_BYT);
    // byte offset bits
    localparam int unsigned OFF_W = $clog2(`TCB_BYT);

    logic siz_err;
    logic aln_err;
    logic rng_err;
    // write item reordered into lane 0 upward
    dat_t wdt_ord;

////////////////////////////////////////////////////////////
// handshake and address split
////////////////////////////////////////////////////////////

    // transfer when both sides agree
    assign trn = vld & rdy;

    assign off = adr[OFF_W-1:0];
    assign idx = adr[MEM_ADR-1:OFF_W];

////////////////////////////////////////////////////////////
// error checks
////////////////////////////////////////////////////////////

    // 64-bit access not supported
    assign siz_err = (siz > siz_t'(OFF_W));

    // offset bits below the size must be zero
    assign aln_err = |(off & off_t'((4'd1 << siz) - 4'd1));

    // anything above 1 KiB is out of range
    assign rng_err = |adr[`TCB_ADR-1:MEM_ADR];

    assign err = siz_err | aln_err | rng_err;

    // only clean writes touch the memory
    assign wr = trn & wen & ~err;

////////////////////////////////////////////////////////////
// byte enables and write lanes
////////////////////////////////////////////////////////////

    always_comb begin
        // contiguous mask of 2**siz bytes, moved up to the offset
        byt = byt_t'(((32'd1 << (32'd1 << siz)) - 32'd1) << off);
        if (err) begin
            byt = '0;
        end
    end

    // big endian swap inside the item, then move to the lane
    assign wdt_ord = item_order(wdt, siz, ndn);
    assign wdat    = dat_t'(wdt_ord << {off, 3'b000});

endmodule

//--- hw/tcb_lite_execute.sv
// memory access stage, byte-masked word memory with a registered read and forwarded attributes
`timescale 1ns/1ps
`include "tcb_lite_params.svh"

module tcb_lite_execute import tcb_lite_pkg::*; (
    input  logic tcb,
    input  logic rst,
    // decoded request
    input  logic trn,
    input  logic wr,
    input  idx_t idx,
    input  off_t off,
    input  byt_t byt,
    input  dat_t wdat,
    input  logic err,
    input  siz_t siz,
    input  logic ndn,
    // handshake back to the manager
    output logic rdy,
    // first response stage
    output logic q_vld,
    output dat_t q_dat,
    output logic q_err,
    output off_t q_off,
    output siz_t q_siz,
    output logic q_ndn
);

    // word organised storage
    dat_t mem [0:`TCB_MEM_WORDS-1];

////////////////////////////////////////////////////////////
// control state
////////////////////////////////////////////////////////////

    // rdy low only during reset, no back-pressure afterwards
    always_ff @(posedge tcb) begin
        if (rst) begin
            rdy   <= 1'b0;
            q_vld <= 1'b0;
        end else begin
            rdy   <= 1'b1;
            // one response per transfer
            q_vld <= trn;
        end
    end

////////////////////////////////////////////////////////////
// memory write
////////////////////////////////////////////////////////////

    // per byte lane write, err already folded into wr
    always_ff @(posedge tcb) begin
        if (wr) begin
            for (int b = 0; b < `TCB_BYT; b++) begin
                if (byt[b]) begin
                    mem[idx][8*b+:8] <= wdat[8*b+:8];
                end
            end
        end
    end

////////////////////////////////////////////////////////////
// memory read and attributes
////////////////////////////////////////////////////////////

    // whole word read, old contents on a same-cycle write
    // attributes travel along for the alignment at the end
    always_ff @(posedge tcb) begin
        if (trn) begin
            q_dat <= mem[idx];
            q_err <= err;
            q_off <= off;
            q_siz <= siz;
            q_ndn <= ndn;
        end
    end

endmodule

//--- hw/tcb_lite_result.sv
// response stage, delays the read word to the bus response edge and aligns it to lane 0
`timescale 1ns/1ps
`include "tcb_lite_params.svh"

module tcb_lite_result import tcb_lite_pkg::*; (
    input  logic tcb,
    input  logic rst,
    // response from execute, one cycle after the transfer
    input  logic q_vld,
    input  dat_t q_dat,
    input  logic q_err,
    input  off_t q_off,
    input  siz_t q_siz,
    input  logic q_ndn,
    // bus response
    output dat_t rdt,
    output logic err
);

    // last stage of the delay line
    logic s_vld;
    dat_t s_dat;
    logic s_err;
    off_t s_off;
    siz_t s_siz;
    logic s_ndn;

////////////////////////////////////////////////////////////
// delay line
////////////////////////////////////////////////////////////

    if (`TCB_DLY == 1) begin : g_nodly
        // execute register already lands on the response edge
        assign s_vld = q_vld;
        assign s_dat = q_dat;
        assign s_err = q_err;
        assign s_off = q_off;
        assign s_siz = q_siz;
        assign s_ndn = q_ndn;
    end else begin : g_dly
        logic vld_p [1:`TCB_DLY-1];
        dat_t dat_p [1:`TCB_DLY-1];
        logic err_p [1:`TCB_DLY-1];
        off_t off_p [1:`TCB_DLY-1];
        siz_t siz_p [1:`TCB_DLY-1];
        logic ndn_p [1:`TCB_DLY-1];

        // valid bits, several responses may be in flight
        always_ff @(posedge tcb) begin
            if (rst) begin
                for (int k = 1; k < `TCB_DLY; k++) begin
                    vld_p[k] <= 1'b0;
                end
            end else begin
                vld_p[1] <= q_vld;
                for (int k = 2; k < `TCB_DLY; k++) begin
                    vld_p[k] <= vld_p[k-1];
                end
            end
        end

        // payload shift, free running
        always_ff @(posedge tcb) begin
            dat_p[1] <= q_dat;
            err_p[1] <= q_err;
            off_p[1] <= q_off;
            siz_p[1] <= q_siz;
            ndn_p[1] <= q_ndn;
            for (int k = 2; k < `TCB_DLY; k++) begin
                dat_p[k] <= dat_p[k-1];
                err_p[k] <= err_p[k-1];
                off_p[k] <= off_p[k-1];
                siz_p[k] <= siz_p[k-1];
                ndn_p[k] <= ndn_p[k-1];
            end
        end

        assign s_vld = vld_p[`TCB_DLY-1];
        assign s_dat = dat_p[`TCB_DLY-1];
        assign s_err = err_p[`TCB_DLY-1];
        assign s_off = off_p[`TCB_DLY-1];
        assign s_siz = siz_p[`TCB_DLY-1];
        assign s_ndn = ndn_p[`TCB_DLY-1];
    end

////////////////////////////////////////////////////////////
// output alignment
////////////////////////////////////////////////////////////

    // down to lane 0, endian swap and size mask in one step
    // zero data when nothing is due or the request failed
    assign rdt = (s_vld & ~s_err) ? item_order(s_dat >> {s_off, 3'b000}, s_siz, s_ndn) : '0;
    assign err = s_vld & s_err;

endmodule

//--- hw/tcb_lite_mem_top.sv
// TCB-Lite memory subordinate top, joins decode, execute and result onto the bus ports
`timescale 1ns/1ps

module tcb_lite_mem_top import tcb_lite_pkg::*; (
    input  logic tcb,
    input  logic rst,
    // request
    input  logic vld,
    input  logic wen,
    input  logic ndn,
    input  adr_t adr,
    input  siz_t siz,
    input  dat_t wdt,
    output logic rdy,
    // response, fixed delay after the transfer
    output dat_t rdt,
    output logic err
);

    // decode to execute, same cycle
    logic d_trn;
    logic d_wr;
    idx_t d_idx;
    off_t d_off;
    byt_t d_byt;
    dat_t d_wdat;
    logic d_err;

    // execute to result, one cycle later
    logic q_vld;
    dat_t q_dat;
    logic q_err;
    off_t q_off;
    siz_t q_siz;
    logic q_ndn;

    tcb_lite_decode u_decode (
        .vld  (vld),
        .rdy  (rdy),
        .wen  (wen),
        .ndn  (ndn),
        .adr  (adr),
        .siz  (siz),
        .wdt  (wdt),
        .trn  (d_trn),
        .wr   (d_wr),
        .idx  (d_idx),
        .off  (d_off),
        .byt  (d_byt),
        .wdat (d_wdat),
        .err  (d_err)
    );

    tcb_lite_execute u_execute (
        .tcb   (tcb),
        .rst   (rst),
        .trn   (d_trn),
        .wr    (d_wr),
        .idx   (d_idx),
        .off   (d_off),
        .byt   (d_byt),
        .wdat  (d_wdat),
        .err   (d_err),
        .siz   (siz),
        .ndn   (ndn),
        .rdy   (rdy),
        .q_vld (q_vld),
        .q_dat (q_dat),
        .q_err (q_err),
        .q_off (q_off),
        .q_siz (q_siz),
        .q_ndn (q_ndn)
    );

    tcb_lite_result u_result (
        .tcb   (tcb),
        .rst   (rst),
        .q_vld (q_vld),
        .q_dat (q_dat),
        .q_err (q_err),
        .q_off (q_off),
        .q_siz (q_siz),
        .q_ndn (q_ndn),
        .rdt   (rdt),
        .err   (err)
    );

endmodule

//--- bench/tcb_lite_clock.sv
// testbench clock and reset source, 10 ns tcb period and a 5-cycle synchronous reset
`timescale 1ns/1ps

module tcb_lite_clock (
    output logic tcb,
    output logic rst
);

    // free running clock
    initial begin
        tcb = 1'b0;
        forever #5 tcb = ~tcb;
    end

    // reset released 1 ns after the fifth edge, like all other stimulus
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge tcb);
        #1;
        rst = 1'b0;
    end

endmodule

//--- bench/tcb_lite_vip_manager.sv
// TCB-Lite manager model that drives requests and collects the fixed-delay responses in order
`timescale 1ns/1ps
`include "tcb_lite_params.svh"

module tcb_lite_vip_manager import tcb_lite_pkg::*; (
    input  logic tcb,
    output logic vld,
    output logic wen,
    output logic ndn,
    output adr_t adr,
    output siz_t siz,
    output dat_t wdt,
    input  logic rdy,
    input  dat_t rdt,
    input  logic err
);

    // captured responses in arrival order
    dat_t rsp_dat [$];
    logic rsp_err [$];
    // edge count at which each pending response shows up
    int   due [$];
    int   cyc = 0;
    int   timeouts = 0;

    initial begin
        vld = 1'b0;
        wen = 1'b0;
        ndn = 1'b0;
        adr = '0;
        siz = '0;
        wdt = '0;
    end

    always @(posedge tcb) begin
        cyc = cyc + 1;
    end

    ////////////////////////////////////////////////////////////
    // response capture
    ////////////////////////////////////////////////////////////

    // mid-cycle sampling while the response is steady
    always @(negedge tcb) begin
        if (due.size() > 0 && due[0] == cyc) begin
            due.delete(0);
            rsp_dat.push_back(rdt);
            rsp_err.push_back(err);
        end
        // handshake lands on the coming edge
        if (vld && rdy) begin
            due.push_back(cyc + `TCB_DLY);
        end
    end

    ////////////////////////////////////////////////////////////
    // request side
    ////////////////////////////////////////////////////////////

    // called 1 ns after an edge and returns 1 ns after its own transfer edge
    task automatic request(input logic w, input logic n, input adr_t a,
                           input siz_t s, input dat_t d);
        int waited;
        waited = 0;
        vld = 1'b1;
        wen = w;
        ndn = n;
        adr = a;
        siz = s;
        wdt = d;
        while (!rdy && waited < 100) begin
            @(posedge tcb);
            #1;
            waited++;
        end
        if (!rdy) begin
            timeouts++;
            $display("timeout: rdy stayed low for %0d cycles on a request", waited);
        end
        @(posedge tcb);
        #1;
    endtask

    task automatic idle();
        vld = 1'b0;
    endtask

    // wait until n responses sit in the queue
    task automatic wait_responses(input int n);
        int waited;
        waited = 0;
        while (rsp_dat.size() < n && waited < n + 20) begin
            @(posedge tcb);
            #1;
            waited++;
        end
        if (rsp_dat.size() < n) begin
            timeouts++;
            $display("timeout: only %0d of %0d responses arrived", rsp_dat.size(), n);
        end
    endtask

    task automatic pop_response(output dat_t d, output logic e);
        d = 'x;
        e = 1'bx;
        if (rsp_dat.size() > 0) begin
            d = rsp_dat.pop_front();
            e = rsp_err.pop_front();
        end
    endtask

    // blocking single accesses
    task automatic read_item(input adr_t a, input siz_t s, input logic n,
                             output dat_t d, output logic e);
        request(1'b0, n, a, s, '0);
        idle();
        wait_responses(1);
        pop_response(d, e);
    endtask

    task automatic write_item(input adr_t a, input siz_t s, input logic n,
                              input dat_t wd, output logic e);
        dat_t d;
        request(1'b1, n, a, s, wd);
        idle();
        wait_responses(1);
        pop_response(d, e);
    endtask

endmodule

//--- bench/tcb_lite_props.sv
// bus protocol assertions, bound into the memory subordinate top
`timescale 1ns/1ps
`include "tcb_lite_params.svh"

module tcb_lite_props import tcb_lite_pkg::*; (
    input logic tcb,
    input logic rst,
    input logic vld,
    input logic rdy,
    input logic wen,
    input adr_t adr,
    input siz_t siz,
    input logic err
);

    // failed assertions, read by the testbench top
    int fails = 0;

    // rdy cleared on every reset edge
    a_rdy_in_reset: assert property (@(posedge tcb) rst |=> !rdy)
        else begin
            fails++;
            $error("rdy high after a reset edge");
        end

    // request fields known while valid
    a_req_known: assert property (@(posedge tcb) disable iff (rst)
        vld |-> !$isunknown({adr, siz, wen}))
        else begin
            fails++;
            $error("request fields unknown while vld is high");
        end

    // err only exactly TCB_DLY cycles after a transfer
    a_err_timing: assert property (@(posedge tcb) disable iff (rst)
        err |-> $past(vld && rdy, `TCB_DLY))
        else begin
            fails++;
            $error("err without a transfer TCB_DLY cycles before");
        end

endmodule

bind tcb_lite_mem_top tcb_lite_props u_props (
    .tcb (tcb),
    .rst (rst),
    .vld (vld),
    .rdy (rdy),
    .wen (wen),
    .adr (adr),
    .siz (siz),
    .err (err)
);

//--- bench/tcb_lite_tb.sv
// testbench top that runs the directed tests on the memory subordinate against a byte model
`timescale 1ns/1ps
`include "tcb_lite_params.svh"

module tcb_lite_tb import tcb_lite_pkg::*; ();

    logic tcb;
    logic rst;
    logic vld;
    logic wen;
    logic ndn;
    adr_t adr;
    siz_t siz;
    dat_t wdt;
    logic rdy;
    dat_t rdt;
    logic err;

    int errors = 0;
    int total;
    int seed;
    // 1 KiB byte reference model
    logic [7:0] ref_mem [0:1023];

    tcb_lite_clock u_clock (.tcb(tcb), .rst(rst));

    tcb_lite_mem_top UUT (
        .tcb (tcb),
        .rst (rst),
        .vld (vld),
        .wen (wen),
        .ndn (ndn),
        .adr (adr),
        .siz (siz),
        .wdt (wdt),
        .rdy (rdy),
        .rdt (rdt),
        .err (err)
    );

    tcb_lite_vip_manager mgr (
        .tcb (tcb),
        .vld (vld),
        .wen (wen),
        .ndn (ndn),
        .adr (adr),
        .siz (siz),
        .wdt (wdt),
        .rdy (rdy),
        .rdt (rdt),
        .err (err)
    );

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // illegal size or misalignment or an address beyond 1 KiB
    function automatic logic access_err(input adr_t a, input siz_t s);
        int len;
        len = 1 << s;
        return (s == 2'd3) || ((a % len) != 0) || (a >= 1024);
    endfunction

    // item byte i sits at a+i or at a+len-1-i for big endian
    task automatic store_ref(input adr_t a, input siz_t s, input logic n, input dat_t d);
        int len;
        len = 1 << s;
        if (!access_err(a, s)) begin
            for (int i = 0; i < len; i++) begin
                ref_mem[n ? a + len - 1 - i : a + i] = d[8*i+:8];
            end
        end
    endtask

    function automatic dat_t load_ref(input adr_t a, input siz_t s, input logic n);
        int   len;
        dat_t res;
        len = 1 << s;
        res = '0;
        if (!access_err(a, s)) begin
            for (int i = 0; i < len; i++) begin
                res[8*i+:8] = ref_mem[n ? a + len - 1 - i : a + i];
            end
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////
    // checks and access helpers
    ////////////////////////////////////////////////////////////

    task automatic check(input string what, input dat_t got, input dat_t exp);
        assert (got === exp) else begin
            errors++;
            $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic verify_read(input adr_t a, input siz_t s, input logic n);
        dat_t d;
        logic e;
        mgr.read_item(a, s, n, d, e);
        check($sformatf("read err adr %h siz %0d", a, s), dat_t'(e), dat_t'(access_err(a, s)));
        check($sformatf("read data adr %h siz %0d ndn %0d", a, s, n), d, load_ref(a, s, n));
    endtask

    task automatic checked_write(input adr_t a, input siz_t s, input logic n, input dat_t d);
        logic e;
        mgr.write_item(a, s, n, d, e);
        check($sformatf("write err adr %h siz %0d", a, s), dat_t'(e), dat_t'(access_err(a, s)));
        store_ref(a, s, n, d);
    endtask

    task automatic wait_reset();
        int waited;
        waited = 0;
        @(posedge tcb);
        #1;
        while ((rst || !rdy) && waited < 50) begin
            @(posedge tcb);
            #1;
            waited++;
        end
        if (rst || !rdy) begin
            errors++;
            $display("reset was not released or rdy stayed low after reset");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    // whole memory written back to back so no read sees unknown bytes
    task automatic fill_memory();
        dat_t pat;
        dat_t d;
        logic e;
        for (int w = 0; w < `TCB_MEM_WORDS; w++) begin
            pat = (32'(4 * w) * 32'h0100_0193) ^ 32'h5bd1_e995;
            store_ref(adr_t'(4 * w), 2'd2, 1'b0, pat);
            mgr.request(1'b1, 1'b0, adr_t'(4 * w), 2'd2, pat);
        end
        mgr.idle();
        mgr.wait_responses(`TCB_MEM_WORDS);
        for (int w = 0; w < `TCB_MEM_WORDS; w++) begin
            mgr.pop_response(d, e);
            check("fill err", dat_t'(e), '0);
        end
    endtask

    task automatic word_rw();
        adr_t list [4] = '{12'h000, 12'h004, 12'h1f0, 12'h3fc};
        for (int k = 0; k < 4; k++) begin
            checked_write(list[k], 2'd2, 1'b0, 32'hc0de_0000 + k);
            verify_read(list[k], 2'd2, 1'b0);
        end
    endtask

    // every byte and halfword lane followed by word and narrow reads
    task automatic narrow_lanes();
        for (int o = 0; o < 4; o++) begin
            checked_write(adr_t'(12'h040 + o), 2'd0, 1'b0, 32'h0000_00a0 + o);
            verify_read(12'h040, 2'd2, 1'b0);
        end
        for (int o = 0; o < 4; o++) begin
            verify_read(adr_t'(12'h040 + o), 2'd0, 1'b0);
        end
        for (int o = 0; o < 4; o += 2) begin
            checked_write(adr_t'(12'h050 + o), 2'd1, 1'b0, 32'hffff_be00 + o);
            verify_read(12'h050, 2'd2, 1'b0);
            verify_read(adr_t'(12'h050 + o), 2'd1, 1'b0);
        end
    endtask

    task automatic endian_swap();
        checked_write(12'h060, 2'd2, 1'b1, 32'h1122_3344);
        verify_read(12'h060, 2'd2, 1'b0);
        verify_read(12'h060, 2'd1, 1'b1);
        verify_read(12'h062, 2'd1, 1'b1);
    endtask

    // misaligned half and word then size 3 and out of range
    task automatic error_cases();
        adr_t list [4] = '{12'h081, 12'h082, 12'h080, 12'h400};
        siz_t sz   [4] = '{2'd1, 2'd2, 2'd3, 2'd2};
        for (int k = 0; k < 4; k++) begin
            checked_write(list[k], sz[k], 1'b0, 32'hdead_beef);
            verify_read(list[k], sz[k], 1'b0);
        end
        // errored writes left the word alone
        verify_read(12'h080, 2'd2, 1'b0);
        // the out of range write would alias word 0
        verify_read(12'h000, 2'd2, 1'b0);
    endtask

    task automatic random_traffic();
        dat_t exp_dat [$];
        logic exp_err [$];
        logic exp_rd  [$];
        logic [31:0] r;
        logic w;
        logic n;
        adr_t a;
        siz_t s;
        dat_t d;
        logic e;
        for (int k = 0; k < 64; k++) begin
            r = $random(seed);
            w = r[0];
            n = r[1];
            s = siz_t'(r[3:2]);
            a = adr_t'(r[13:4]);
            // out of range now and then and aligned most of the time
            if (r[16:14] == 3'd0) a[10] = 1'b1;
            if (r[17] || r[18]) a = a & ~adr_t'((1 << s) - 1);
            d = $random(seed);
            exp_rd.push_back(!w);
            exp_err.push_back(access_err(a, s));
            exp_dat.push_back(w ? '0 : load_ref(a, s, n));
            if (w) store_ref(a, s, n, d);
            mgr.request(w, n, a, s, d);
        end
        mgr.idle();
        mgr.wait_responses(64);
        for (int k = 0; k < 64; k++) begin
            mgr.pop_response(d, e);
            check($sformatf("random err #%0d", k), dat_t'(e), dat_t'(exp_err[k]));
            if (exp_rd[k]) check($sformatf("random data #%0d", k), d, exp_dat[k]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // sequence and verdict
    ////////////////////////////////////////////////////////////

    initial begin
        seed = 32'h2d098d80;
        wait_reset();
        fill_memory();
        word_rw();
        narrow_lanes();
        endian_swap();
        error_cases();
        random_traffic();
        total = errors + mgr.timeouts + UUT.u_props.fails;
        $display("errors %0d, timeouts %0d, assertion failures %0d",
                 errors, mgr.timeouts, UUT.u_props.fails);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // hard stop if the run hangs anywhere
    initial begin
        #200_000;
        $display("watchdog expired, the tests did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- list.f
+incdir+hw
hw/tcb_lite_pkg.sv
hw/tcb_lite_decode.sv
hw/tcb_lite_execute.sv
hw/tcb_lite_result.sv
hw/tcb_lite_mem_top.sv
bench/tcb_lite_clock.sv
bench/tcb_lite_vip_manager.sv
bench/tcb_lite_props.sv
bench/tcb_lite_tb.sv
